/* source/switch_macros.svh */
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

// switch geometry
`define NUM_PORTS 4
`define MAC_W 48

// dst + src mac bytes at the front of every frame
`define HDR_BYTES 12

// 16 table slots
`define FDB_IDX_W 4

// bytes per egress fifo, power of two
`define EGRESS_DEPTH 32

`endif

/* source/switch_pkg.sv */
`include "switch_macros.svh"

package switch_pkg;

    // one byte of a frame, last marks the final byte
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } frame_beat_t;

    // one bit per switch port
    typedef logic [`NUM_PORTS-1:0] port_map_t;

    typedef logic [$clog2(`NUM_PORTS)-1:0] port_idx_t;

    // frame processor phases
    typedef enum logic [1:0] {
        st_header,
        st_lookup,
        st_replay,
        st_body
    } fp_state_t;

endpackage

/* source/fdb_pkg.sv */
`include "switch_macros.svh"

package fdb_pkg;
    import switch_pkg::*;

    // learn src, look up dst
    typedef struct packed {
        logic [`MAC_W-1:0] dst_mac;
        logic [`MAC_W-1:0] src_mac;
        port_idx_t         src_port;
    } fdb_req_t;

    typedef struct packed {
        logic      hit;
        port_idx_t port;
    } fdb_resp_t;

    typedef struct packed {
        logic              valid;
        logic [`MAC_W-1:0] mac;
        port_idx_t         port;
    } fdb_entry_t;

endpackage

/* source/ingress_arbiter.sv */
`include "switch_macros.svh"

module ingress_arbiter
    import switch_pkg::*;
(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  frame_beat_t [`NUM_PORTS-1:0]   i_rx_beat,
    input  port_map_t                      i_rx_valid,
    output port_map_t                      o_rx_ready,
    output frame_beat_t                    o_sel_beat,
    output logic                           o_sel_valid,
    input  logic                           i_sel_ready,
    output port_idx_t                      o_sel_port
);

    port_idx_t ptr;
    port_idx_t grant;
    port_idx_t pick;
    logic      busy;

    // first requester at or after the pointer
    always_comb begin
        port_idx_t idx;
        pick = ptr;
        for (int k = `NUM_PORTS - 1; k >= 0; k--) begin
            idx = ptr + port_idx_t'(k);
            if (i_rx_valid[idx]) begin
                pick = idx;
            end
        end
    end

    // grant is locked until the last beat goes through
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy  <= 1'b0;
            grant <= '0;
            ptr   <= '0;
        end else if (!busy) begin
            if (|i_rx_valid) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if (o_sel_valid && i_sel_ready && o_sel_beat.last) begin
            busy <= 1'b0;
            ptr  <= grant + 1'b1;
        end
    end

    assign o_sel_beat  = i_rx_beat[grant];
    assign o_sel_valid = busy & i_rx_valid[grant];
    assign o_sel_port  = grant;

    // ready only back to the granted port
    always_comb begin
        o_rx_ready        = '0;
        o_rx_ready[grant] = busy & i_sel_ready;
    end

endmodule

/* source/frame_process.sv */
`include "switch_macros.svh"

module frame_process
    import switch_pkg::*;
    import fdb_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  frame_beat_t i_sel_beat,
    input  logic        i_sel_valid,
    output logic        o_sel_ready,
    input  port_idx_t   i_sel_port,
    input  port_map_t   i_link,
    output logic        o_lookup_valid,
    output fdb_req_t    o_lookup_req,
    input  logic        i_lookup_valid,
    input  fdb_resp_t   i_lookup_resp,
    output frame_beat_t o_q_beat,
    output logic        o_q_valid,
    input  logic        i_q_ready,
    output port_map_t   o_q_map
);

    localparam int CNT_W = $clog2(`HDR_BYTES);
    localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(`HDR_BYTES - 1);

    fp_state_t                   state;
    logic [CNT_W-1:0]            cnt;
    logic                        drop;
    logic [0:`HDR_BYTES-1][7:0]  hdr;
    port_idx_t                   src_port;
    port_map_t                   fwd_map;

    // dst mac is bytes 0..5, src mac bytes 6..11
    assign o_lookup_req = '{dst_mac: hdr[0:5], src_mac: hdr[6:11], src_port: src_port};

    // unicast on hit, flood on miss, never back to the source
    always_comb begin
        if (i_lookup_resp.hit) begin
            fwd_map = port_map_t'(1) << i_lookup_resp.port;
        end else begin
            fwd_map = '1;
        end
        fwd_map[src_port] = 1'b0;
        fwd_map = fwd_map & i_link;
    end

    always_comb begin
        o_sel_ready = 1'b0;
        o_q_valid   = 1'b0;
        o_q_beat    = i_sel_beat;
        case (state)
            st_header: o_sel_ready = 1'b1;
            st_replay: begin
                o_q_valid     = 1'b1;
                o_q_beat.data = hdr[cnt];
                o_q_beat.last = 1'b0;
            end
            st_body: begin
                // drained frames are swallowed at full rate
                o_sel_ready = drop | i_q_ready;
                o_q_valid   = ~drop & i_sel_valid;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state          <= st_header;
            cnt            <= '0;
            drop           <= 1'b0;
            o_lookup_valid <= 1'b0;
            o_q_map        <= '0;
        end else begin
            o_lookup_valid <= 1'b0;
            case (state)
                st_header: begin
                    if (i_sel_valid) begin
                        if (cnt == HDR_LAST) begin
                            cnt            <= '0;
                            state          <= st_lookup;
                            o_lookup_valid <= 1'b1;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                st_lookup: begin
                    if (i_lookup_valid) begin
                        o_q_map <= fwd_map;
                        drop    <= (fwd_map == '0);
                        state   <= (fwd_map == '0) ? st_body : st_replay;
                    end
                end
                st_replay: begin
                    if (i_q_ready) begin
                        if (cnt == HDR_LAST) begin
                            cnt   <= '0;
                            state <= st_body;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                st_body: begin
                    if (i_sel_valid && o_sel_ready && i_sel_beat.last) begin
                        state <= st_header;
                    end
                end
                default: state <= st_header;
            endcase
        end
    end

    // header bytes and source port, captured as they arrive
    always_ff @(posedge i_clk) begin
        if (state == st_header && i_sel_valid) begin
            hdr[cnt] <= i_sel_beat.data;
            if (cnt == '0) begin
                src_port <= i_sel_port;
            end
        end
    end

endmodule

/* source/mac_table.sv */
`include "switch_macros.svh"

module mac_table
    import switch_pkg::*;
    import fdb_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_req_valid,
    input  fdb_req_t  i_req,
    output logic      o_resp_valid,
    output fdb_resp_t o_resp
);

    localparam int FDB_DEPTH = 1 << `FDB_IDX_W;

    fdb_entry_t table_q [FDB_DEPTH];

    logic       s1_valid;
    fdb_req_t   s1_req;
    fdb_entry_t s1_entry;

    // xor fold of the six address bytes
    function automatic logic [`FDB_IDX_W-1:0] fdb_hash(input logic [`MAC_W-1:0] mac);
        logic [7:0] x;
        x = '0;
        for (int b = 0; b < `MAC_W / 8; b++) begin
            x = x ^ mac[8*b +: 8];
        end
        return x[`FDB_IDX_W-1:0];
    endfunction

    // stage one, read the dst slot
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= i_req_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_req   <= i_req;
        s1_entry <= table_q[fdb_hash(i_req.dst_mac)];
    end

    // stage two, answer and learn
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_resp.hit  <= s1_entry.valid && (s1_entry.mac == s1_req.dst_mac);
        o_resp.port <= s1_entry.port;
    end

    // last writer wins the slot
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < FDB_DEPTH; i++) begin
                table_q[i].valid <= 1'b0;
            end
        end else if (s1_valid) begin
            table_q[fdb_hash(s1_req.src_mac)] <= '{
                valid: 1'b1,
                mac:   s1_req.src_mac,
                port:  s1_req.src_port
            };
        end
    end

endmodule

/* source/egress_queues.sv */
`include "switch_macros.svh"

module egress_queues
    import switch_pkg::*;
(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  frame_beat_t                    i_q_beat,
    input  logic                           i_q_valid,
    output logic                           o_q_ready,
    input  port_map_t                      i_q_map,
    output frame_beat_t [`NUM_PORTS-1:0]   o_tx_beat,
    output port_map_t                      o_tx_valid,
    input  port_map_t                      i_tx_ready
);

    localparam int PTR_W = $clog2(`EGRESS_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(`EGRESS_DEPTH);

    port_map_t full;
    logic      wr;

    // every selected queue must take the byte
    assign o_q_ready = &(~i_q_map | ~full);
    assign wr        = i_q_valid & o_q_ready;

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_queue
        frame_beat_t      mem [`EGRESS_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W:0]   count;
        logic             push;
        logic             pop;

        assign push          = wr & i_q_map[p];
        assign pop           = o_tx_valid[p] & i_tx_ready[p];
        assign full[p]       = (count == DEPTH_CNT);
        assign o_tx_valid[p] = (count != '0);
        assign o_tx_beat[p]  = mem[rd_ptr];

        always_ff @(posedge i_clk) begin
            if (i_reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count + push - pop;
            end
        end

        always_ff @(posedge i_clk) begin
            if (push) begin
                mem[wr_ptr] <= i_q_beat;
            end
        end
    end

endmodule

/* source/switch_top.sv */
`include "switch_macros.svh"

module switch_top
    import switch_pkg::*;
    import fdb_pkg::*;
(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  frame_beat_t [`NUM_PORTS-1:0]   i_rx_beat,
    input  port_map_t                      i_rx_valid,
    output port_map_t                      o_rx_ready,
    input  port_map_t                      i_link,
    output frame_beat_t [`NUM_PORTS-1:0]   o_tx_beat,
    output port_map_t                      o_tx_valid,
    input  port_map_t                      i_tx_ready
);

    frame_beat_t sel_beat;
    logic        sel_valid;
    logic        sel_ready;
    port_idx_t   sel_port;

    logic        lookup_valid;
    fdb_req_t    lookup_req;
    logic        lookup_done;
    fdb_resp_t   lookup_resp;

    frame_beat_t q_beat;
    logic        q_valid;
    logic        q_ready;
    port_map_t   q_map;

    ingress_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx_beat   (i_rx_beat),
        .i_rx_valid  (i_rx_valid),
        .o_rx_ready  (o_rx_ready),
        .o_sel_beat  (sel_beat),
        .o_sel_valid (sel_valid),
        .i_sel_ready (sel_ready),
        .o_sel_port  (sel_port)
    );

    frame_process u_frame_process (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_sel_beat     (sel_beat),
        .i_sel_valid    (sel_valid),
        .o_sel_ready    (sel_ready),
        .i_sel_port     (sel_port),
        .i_link         (i_link),
        .o_lookup_valid (lookup_valid),
        .o_lookup_req   (lookup_req),
        .i_lookup_valid (lookup_done),
        .i_lookup_resp  (lookup_resp),
        .o_q_beat       (q_beat),
        .o_q_valid      (q_valid),
        .i_q_ready      (q_ready),
        .o_q_map        (q_map)
    );

    mac_table u_mac_table (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req_valid  (lookup_valid),
        .i_req        (lookup_req),
        .o_resp_valid (lookup_done),
        .o_resp       (lookup_resp)
    );

    egress_queues u_egress (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_q_beat   (q_beat),
        .i_q_valid  (q_valid),
        .o_q_ready  (q_ready),
        .i_q_map    (q_map),
        .o_tx_beat  (o_tx_beat),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready)
    );

endmodule

/* test/tb_top.sv */
`include "switch_macros.svh"

module tb_top
    import switch_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NP = `NUM_PORTS;
    localparam int SLOTS = 1 << `FDB_IDX_W;
    localparam logic [`MAC_W-1:0] UNKNOWN = 48'h0200_0000_00F7;
    localparam logic [`MAC_W-1:0] SECOND_P0 = 48'h0200_0000_0020;

    logic                    i_clk;
    logic                    i_reset;
    frame_beat_t [NP-1:0]    i_rx_beat;
    port_map_t               i_rx_valid;
    port_map_t               o_rx_ready;
    port_map_t               i_link;
    frame_beat_t [NP-1:0]    o_tx_beat;
    port_map_t               o_tx_valid;
    port_map_t               i_tx_ready;

    frame_beat_t       rx_q [NP][$];
    int                len_q [NP][$];
    frame_beat_t       exp_q [NP][$];
    logic              in_frame [NP];
    logic              ref_valid [SLOTS];
    logic [`MAC_W-1:0] ref_mac [SLOTS];
    port_idx_t         ref_port [SLOTS];
    logic [15:0]       lfsr;
    logic              gaps;
    int                bytes_sent;

    switch_top DUT (.*);

    always #5 i_clk = ~i_clk;

    // galois lfsr stepped once per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr[0]};
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return r;
    endfunction

    function automatic logic [`MAC_W-1:0] station(input int i);
        return 48'h0200_0000_0010 + 48'(i);
    endfunction

    function automatic int mac_hash(input logic [`MAC_W-1:0] mac);
        logic [7:0] f;
        f = mac[47:40] ^ mac[39:32] ^ mac[31:24] ^ mac[23:16] ^ mac[15:8] ^ mac[7:0];
        return int'(f) % SLOTS;
    endfunction

    // lookup sees only earlier frames and the source is learned after it
    function automatic port_map_t fwd_map(input logic [`MAC_W-1:0] dst,
                                          input logic [`MAC_W-1:0] src,
                                          input port_idx_t sp, input port_map_t link);
        int        d;
        int        s;
        port_map_t m;
        d = mac_hash(dst);
        s = mac_hash(src);
        if (ref_valid[d] && ref_mac[d] == dst) begin
            m = '0;
            m[ref_port[d]] = 1'b1;
        end else begin
            m = '1;
        end
        m[sp] = 1'b0;
        ref_valid[s] = 1'b1;
        ref_mac[s] = src;
        ref_port[s] = sp;
        return m & link;
    endfunction

    task automatic compare_beat(input string name, input frame_beat_t got,
                                input frame_beat_t exp);
        if (got !== exp) begin
            $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "beat mismatch");
        end
    endtask

    task automatic compare_map(input string name, input port_map_t got, input port_map_t exp);
        if (got !== exp) begin
            $display("ERROR %0t ns %s got %b expected %b", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "port map mismatch");
        end
    endtask

    task automatic send_frame(input int port, input logic [`MAC_W-1:0] dst,
                              input logic [`MAC_W-1:0] src, input int len);
        logic [95:0] hdr;
        frame_beat_t b;
        hdr = {dst, src};
        for (int i = 0; i < len; i++) begin
            if (i < `HDR_BYTES) begin
                b.data = hdr[95 - 8*i -: 8];
            end else begin
                b.data = 8'(rand_bits(8));
            end
            b.last = (i == len - 1);
            rx_q[port].push_back(b);
        end
        len_q[port].push_back(len);
        bytes_sent += len;
    endtask

    // 14 to 40 bytes to one of the stations or to the unknown address
    task automatic send_random(input int port, input logic [`MAC_W-1:0] src);
        int len;
        int pick;
        len = 14 + int'(rand_bits(5)) % 27;
        pick = int'(rand_bits(3)) % 5;
        send_frame(port, (pick == 4) ? UNKNOWN : station(pick), src, len);
    endtask

    task automatic expect_frame(input int p);
        logic [`MAC_W-1:0] dst;
        logic [`MAC_W-1:0] src;
        port_map_t         map;
        int                len;
        len = len_q[p].pop_front();
        for (int i = 0; i < 6; i++) begin
            dst = {dst[39:0], rx_q[p][i].data};
            src = {src[39:0], rx_q[p][i + 6].data};
        end
        map = fwd_map(dst, src, port_idx_t'(p), i_link);
        for (int q = 0; q < NP; q++) begin
            for (int i = 0; i < len && map[q]; i++) begin
                exp_q[q].push_back(rx_q[p][i]);
            end
        end
    endtask

    // wait until every frame went in and every queue ran dry
    task automatic drain();
        int pending;
        do begin
            @(negedge i_clk);
            pending = 0;
            for (int p = 0; p < NP; p++) begin
                pending += rx_q[p].size();
            end
        end while (pending != 0 || o_tx_valid != '0);
    endtask

    // ingress driver
    always @(posedge i_clk) begin
        for (int p = 0; p < NP; p++) begin
            if (i_rx_valid[p] && o_rx_ready[p]) begin
                if (!in_frame[p]) begin
                    expect_frame(p);
                end
                in_frame[p] = !rx_q[p][0].last;
                void'(rx_q[p].pop_front());
            end
        end
        #1;
        for (int p = 0; p < NP; p++) begin
            i_rx_valid[p] = (rx_q[p].size() != 0);
            i_rx_beat[p] = (rx_q[p].size() != 0) ? rx_q[p][0] : '0;
            // egress ready one cycle in four, so the queues fill up
            i_tx_ready[p] = gaps ? (rand_bits(2) == 0) : 1'b1;
        end
    end

    // egress compare
    always @(posedge i_clk) begin
        for (int p = 0; p < NP; p++) begin
            if (o_tx_valid[p] && i_tx_ready[p]) begin
                if (exp_q[p].size() == 0) begin
                    $display("egress port %0d sent a byte nobody expected at %0t ns", p, $time);
                    $display("** FAIL **");
                    $fatal(1, "unexpected byte");
                end else begin
                    compare_beat($sformatf("o_tx_beat[%0d]", p), o_tx_beat[p],
                                 exp_q[p].pop_front());
                end
            end
        end
    end

    initial begin
        longint cycles;
        cycles = 0;
        while (cycles <= 50 * longint'(bytes_sent) + 1000) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", cycles);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        int left;
        i_clk = 1'b0;
        i_reset = 1'b1;
        i_rx_beat = '0;
        i_rx_valid = '0;
        i_link = '1;
        i_tx_ready = '1;
        lfsr = 16'd47;
        gaps = 1'b0;
        bytes_sent = 0;
        for (int p = 0; p < NP; p++) begin
            in_frame[p] = 1'b0;
        end
        for (int i = 0; i < SLOTS; i++) begin
            ref_valid[i] = 1'b0;
        end
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        @(negedge i_clk);
        compare_map("o_rx_ready", o_rx_ready, '0);
        compare_map("o_tx_valid", o_tx_valid, '0);

        // unknown destination floods
        send_frame(0, UNKNOWN, station(0), 20);
        drain();
        // learned unicast and a hit back onto its own source
        send_frame(2, station(0), station(2), 30);
        drain();
        send_frame(0, station(0), SECOND_P0, 17);
        drain();
        send_frame(1, station(2), station(1), 25);
        drain();

        // port 2 link down
        @(posedge i_clk);
        #1;
        i_link = 4'b1011;
        send_frame(1, station(2), station(1), 22);
        send_frame(1, UNKNOWN, station(1), 19);
        send_frame(0, UNKNOWN, station(0), 16);
        drain();
        @(posedge i_clk);
        #1;
        i_link = '1;

        // all ports at once
        for (int n = 0; n < 4; n++) begin
            for (int p = 0; p < NP; p++) begin
                send_random(p, station(p));
            end
        end
        drain();

        // stations move around while egress stalls at random
        gaps = 1'b1;
        for (int n = 0; n < 16; n++) begin
            send_random(int'(rand_bits(2)), station(int'(rand_bits(2))));
        end
        drain();
        gaps = 1'b0;
        repeat (20) @(negedge i_clk);

        left = 0;
        for (int p = 0; p < NP; p++) begin
            left += exp_q[p].size();
        end
        if (left != 0) begin
            $display("%0d expected bytes never left the egress ports", left);
            $display("** FAIL **");
            $fatal(1, "missing bytes");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+source
source/switch_pkg.sv
source/fdb_pkg.sv
source/ingress_arbiter.sv
source/frame_process.sv
source/mac_table.sv
source/egress_queues.sv
source/switch_top.sv
test/tb_top.sv
